// File: logic/tea_pkg.sv
package tea_pkg;

	typedef logic [31:0] word_t;
	typedef logic [7:0] scan_code_t;
	typedef logic [2:0] field_idx_t; // v0, v1, k0..k3
	typedef logic [6:0] seg_t;       // active low

	localparam word_t TEA_DELTA = 32'h9E37_79B9;
	localparam word_t TEA_DEC_SUM = 32'hC6EF_3720; // delta times 32
	localparam int TEA_ROUNDS = 32;
	localparam int NUM_FIELDS = 6;

	// set 2 make codes
	localparam scan_code_t SC_ENTER = 8'h5A;
	localparam scan_code_t SC_SPACE = 8'h29;
	localparam scan_code_t SC_BREAK = 8'hF0;
	localparam scan_code_t SC_ESC = 8'h76;
	localparam scan_code_t SC_ENC = 8'h24; // E
	localparam scan_code_t SC_DEC = 8'h23; // D

	// index is the digit value
	localparam scan_code_t SC_DIGIT [10] = '{
		8'h45, 8'h16, 8'h1E, 8'h26, 8'h25,
		8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
	};

	typedef enum logic [4:0] {
		LOAD, LOAD_WAIT,
		WAIT_ENC,
		E_SUM, E_RES1, E_V0, E_RES2, E_V1,
		E_SHOW0, E_SHOW1,
		WAIT_DEC,
		D_RES1, D_V1, D_RES2, D_V0, D_SUM,
		D_SHOW0, D_SHOW1,
		FINAL
	} seq_state_t;

endpackage

// File: logic/scan_entry.sv
`timescale 1ns/1ps

module scan_entry import tea_pkg::*; (
	input logic clk,
	input logic resetFlag,
	input scan_code_t scan_code,
	input logic scan_valid,
	input logic load_en,
	input logic clear,
	output scan_code_t held_code,
	output logic abort,
	output logic digit_valid,
	output logic [3:0] digit,
	output field_idx_t field
);

	logic after_break; // previous strobe was F0
	logic space_down;  // last make code was space
	logic make_strobe;
	logic space_step;
	logic field_last;

	assign make_strobe = scan_valid && scan_code != SC_BREAK && !after_break;
	assign space_step = make_strobe && scan_code == SC_SPACE && !space_down;
	assign field_last = field == field_idx_t'(NUM_FIELDS - 1);

	always_ff @(posedge clk) begin
		if (resetFlag) begin
			held_code <= '0;
			abort <= 1'b0;
		end else begin
			abort <= make_strobe && scan_code == SC_ESC; // ignore the escape release
			if (scan_valid)
				held_code <= scan_code;
		end
	end

	// key history, filters releases and typematic repeats
	always_ff @(posedge clk) begin
		if (resetFlag || abort) begin
			after_break <= 1'b0;
			space_down <= 1'b0;
		end else if (scan_valid) begin
			after_break <= scan_code == SC_BREAK;
			if (make_strobe)
				space_down <= scan_code == SC_SPACE;
		end
	end

	always_ff @(posedge clk) begin
		if (resetFlag || clear || abort) begin
			field <= '0;
		end else if (load_en && space_step && !field_last) begin
			field <= field + 3'd1; // stays on k3 after the last field
		end
	end

	// level decode of the held code
	always_comb begin
		digit_valid = 1'b0;
		digit = '0;
		for (int i = 0; i < 10; i++) begin
			if (held_code == SC_DIGIT[i]) begin
				digit_valid = 1'b1;
				digit = 4'(i);
			end
		end
	end

endmodule

// File: logic/operand_regs.sv
`timescale 1ns/1ps

module operand_regs import tea_pkg::*; (
	input logic clk,
	input logic resetFlag,
	input logic abort,
	input logic clear,
	input logic load_en,
	input logic digit_valid,
	input logic [3:0] digit,
	input field_idx_t field,
	output word_t v0_init,
	output word_t v1_init,
	output word_t k0,
	output word_t k1,
	output word_t k2,
	output word_t k3
);

	word_t words [NUM_FIELDS]; // in entry order
	logic wr_en;

	assign wr_en = load_en && digit_valid;

	always_ff @(posedge clk) begin
		if (resetFlag || clear || abort) begin
			for (int i = 0; i < NUM_FIELDS; i++)
				words[i] <= '0;
		end else if (wr_en) begin
			words[field] <= word_t'(digit); // one decimal digit per word
		end
	end

	assign v0_init = words[0];
	assign v1_init = words[1];
	assign k0 = words[2];
	assign k1 = words[3];
	assign k2 = words[4];
	assign k3 = words[5];

	// field stepping in scan_entry must never run past k3
	field_in_range: assert property (
		@(posedge clk) disable iff (resetFlag)
		wr_en |-> field < field_idx_t'(NUM_FIELDS)
	);

endmodule

// File: logic/tea_round_unit.sv
`timescale 1ns/1ps

module tea_round_unit import tea_pkg::*; (
	input logic clk,
	input logic resetFlag,
	input logic abort,
	input logic clear,
	input logic enc_start,
	input logic enc_sum,
	input logic enc_res1,
	input logic enc_v0,
	input logic enc_res2,
	input logic enc_v1,
	input logic dec_start,
	input logic dec_res1,
	input logic dec_v1,
	input logic dec_res2,
	input logic dec_v0,
	input logic dec_sum,
	input word_t v0_init,
	input word_t v1_init,
	input word_t k0,
	input word_t k1,
	input word_t k2,
	input word_t k3,
	output word_t v0,
	output word_t v1
);

	word_t sum;
	word_t t_shl, t_add, t_shr; // partial terms of one half round
	word_t src, key_a, key_b;
	word_t mix;
	logic pick_v1;
	logic res_en;

	// v1 pairs with k0/k1, v0 with k2/k3
	assign pick_v1 = enc_res1 | dec_res2;
	assign res_en = enc_res1 | enc_res2 | dec_res1 | dec_res2;
	assign src = pick_v1 ? v1 : v0;
	assign key_a = pick_v1 ? k0 : k2;
	assign key_b = pick_v1 ? k1 : k3;
	assign mix = t_shl ^ t_add ^ t_shr;

	always_ff @(posedge clk) begin
		if (resetFlag || clear || abort) begin
			v0 <= '0;
			v1 <= '0;
			sum <= '0;
			t_shl <= '0;
			t_add <= '0;
			t_shr <= '0;
		end else begin
			if (enc_start) begin
				v0 <= v0_init;
				v1 <= v1_init;
				sum <= '0;
			end
			if (dec_start)
				sum <= TEA_DEC_SUM; // works on the encrypted words in place
			if (enc_sum)
				sum <= sum + TEA_DELTA;
			if (dec_sum)
				sum <= sum - TEA_DELTA;
			if (res_en) begin
				t_shl <= (src << 4) + key_a;
				t_add <= src + sum;
				t_shr <= (src >> 5) + key_b;
			end
			if (enc_v0)
				v0 <= v0 + mix;
			if (enc_v1)
				v1 <= v1 + mix;
			if (dec_v1)
				v1 <= v1 - mix;
			if (dec_v0)
				v0 <= v0 - mix;
		end
	end

	// sequencer holds at most one wait state at a time
	start_exclusive: assert property (
		@(posedge clk) disable iff (resetFlag)
		!(enc_start && dec_start)
	);

endmodule

// File: logic/tea_sequencer.sv
`timescale 1ns/1ps

module tea_sequencer import tea_pkg::*; (
	input logic clk,
	input logic resetFlag,
	input logic abort,
	input scan_code_t held_code,
	output logic load_en,
	output logic clear,
	output logic enc_start,
	output logic enc_sum,
	output logic enc_res1,
	output logic enc_v0,
	output logic enc_res2,
	output logic enc_v1,
	output logic dec_start,
	output logic dec_res1,
	output logic dec_v1,
	output logic dec_res2,
	output logic dec_v0,
	output logic dec_sum,
	output logic show_v0,
	output logic show_v1
);

	seq_state_t state, next_state;
	logic [5:0] round_cnt;
	logic last_round;

	assign last_round = round_cnt == 6'(TEA_ROUNDS);

	always_comb begin
		next_state = state;
		case (state)
			LOAD: if (held_code == SC_ENTER) next_state = LOAD_WAIT;
			LOAD_WAIT: if (held_code != SC_ENTER) next_state = WAIT_ENC; // wait for next key
			WAIT_ENC: if (held_code == SC_ENC) next_state = E_SUM;
			E_SUM: next_state = E_RES1;
			E_RES1: next_state = E_V0;
			E_V0: next_state = E_RES2;
			E_RES2: next_state = E_V1;
			E_V1: next_state = last_round ? E_SHOW0 : E_SUM;
			E_SHOW0: next_state = E_SHOW1;
			E_SHOW1: next_state = WAIT_DEC;
			WAIT_DEC: if (held_code == SC_DEC) next_state = D_RES1;
			D_RES1: next_state = D_V1;
			D_V1: next_state = D_RES2;
			D_RES2: next_state = D_V0;
			D_V0: next_state = D_SUM;
			D_SUM: next_state = last_round ? D_SHOW0 : D_RES1;
			D_SHOW0: next_state = D_SHOW1;
			D_SHOW1: next_state = FINAL;
			FINAL: next_state = LOAD;
			default: next_state = LOAD;
		endcase
	end

	always_ff @(posedge clk) begin
		if (resetFlag || abort) begin
			state <= LOAD;
			round_cnt <= '0;
		end else begin
			state <= next_state;
			if (state == WAIT_ENC || state == WAIT_DEC)
				round_cnt <= '0;
			else if (state == E_SUM || state == D_RES1)
				round_cnt <= round_cnt + 6'd1; // counts at the head of each round
		end
	end

	assign load_en = state == LOAD;
	assign clear = state == FINAL;
	assign enc_start = state == WAIT_ENC; // copies operands until E arrives
	assign enc_sum = state == E_SUM;
	assign enc_res1 = state == E_RES1;
	assign enc_v0 = state == E_V0;
	assign enc_res2 = state == E_RES2;
	assign enc_v1 = state == E_V1;
	assign dec_start = state == WAIT_DEC;
	assign dec_res1 = state == D_RES1;
	assign dec_v1 = state == D_V1;
	assign dec_res2 = state == D_RES2;
	assign dec_v0 = state == D_V0;
	assign dec_sum = state == D_SUM;
	assign show_v0 = state == E_SHOW0 || state == D_SHOW0;
	assign show_v1 = state == E_SHOW1 || state == D_SHOW1;

	round_cnt_bound: assert property (
		@(posedge clk) disable iff (resetFlag)
		round_cnt <= 6'(TEA_ROUNDS)
	);

endmodule

// File: logic/result_display.sv
`timescale 1ns/1ps

module result_display import tea_pkg::*; (
	input logic clk,
	input logic resetFlag,
	input logic abort,
	input logic show_v0,
	input logic show_v1,
	input word_t v0,
	input word_t v1,
	output seg_t hex0,
	output seg_t hex1,
	output seg_t hex2,
	output seg_t hex3,
	output seg_t hex4,
	output seg_t hex5,
	output logic [7:0] ledr
);

	word_t result; // {v1[15:0], v0[15:0]}

	function automatic seg_t hex_seg(input logic [3:0] nib);
		case (nib)
			4'h0: return 7'b100_0000;
			4'h1: return 7'b111_1001;
			4'h2: return 7'b010_0100;
			4'h3: return 7'b011_0000;
			4'h4: return 7'b001_1001;
			4'h5: return 7'b001_0010;
			4'h6: return 7'b000_0010;
			4'h7: return 7'b111_1000;
			4'h8: return 7'b000_0000;
			4'h9: return 7'b001_1000;
			4'hA: return 7'b000_1000;
			4'hB: return 7'b000_0011;
			4'hC: return 7'b100_0110;
			4'hD: return 7'b010_0001;
			4'hE: return 7'b000_0110;
			default: return 7'b000_1110; // F
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (resetFlag || abort) begin
			result <= '0;
		end else begin
			if (show_v0)
				result[15:0] <= v0[15:0];
			if (show_v1)
				result[31:16] <= v1[15:0];
		end
	end

	// top nibble of each half goes to the leds
	assign hex0 = hex_seg(result[3:0]);
	assign hex1 = hex_seg(result[7:4]);
	assign hex2 = hex_seg(result[11:8]);
	assign hex3 = hex_seg(result[19:16]);
	assign hex4 = hex_seg(result[23:20]);
	assign hex5 = hex_seg(result[27:24]);
	assign ledr = {result[31:28], result[15:12]};

endmodule

// File: logic/tea_keypad_top.sv
`timescale 1ns/1ps

module tea_keypad_top import tea_pkg::*; (
	input logic clk,
	input logic resetFlag,
	input scan_code_t scan_code,
	input logic scan_valid,
	output seg_t hex0,
	output seg_t hex1,
	output seg_t hex2,
	output seg_t hex3,
	output seg_t hex4,
	output seg_t hex5,
	output logic [7:0] ledr
);

	scan_code_t held_code;
	logic abort, load_en, clear;
	logic digit_valid;
	logic [3:0] digit;
	field_idx_t field;
	word_t v0_init, v1_init, k0, k1, k2, k3;
	word_t v0, v1;
	logic enc_start, enc_sum, enc_res1, enc_v0, enc_res2, enc_v1;
	logic dec_start, dec_res1, dec_v1, dec_res2, dec_v0, dec_sum;
	logic show_v0, show_v1;

	scan_entry u_scan_entry (
		.clk(clk), .resetFlag(resetFlag),
		.scan_code(scan_code), .scan_valid(scan_valid),
		.load_en(load_en), .clear(clear),
		.held_code(held_code), .abort(abort),
		.digit_valid(digit_valid), .digit(digit), .field(field)
	);

	operand_regs u_operand_regs (
		.clk(clk), .resetFlag(resetFlag), .abort(abort), .clear(clear),
		.load_en(load_en), .digit_valid(digit_valid), .digit(digit), .field(field),
		.v0_init(v0_init), .v1_init(v1_init),
		.k0(k0), .k1(k1), .k2(k2), .k3(k3)
	);

	tea_sequencer u_tea_sequencer (
		.clk(clk), .resetFlag(resetFlag), .abort(abort), .held_code(held_code),
		.load_en(load_en), .clear(clear),
		.enc_start(enc_start), .enc_sum(enc_sum), .enc_res1(enc_res1),
		.enc_v0(enc_v0), .enc_res2(enc_res2), .enc_v1(enc_v1),
		.dec_start(dec_start), .dec_res1(dec_res1), .dec_v1(dec_v1),
		.dec_res2(dec_res2), .dec_v0(dec_v0), .dec_sum(dec_sum),
		.show_v0(show_v0), .show_v1(show_v1)
	);

	tea_round_unit u_tea_round_unit (
		.clk(clk), .resetFlag(resetFlag), .abort(abort), .clear(clear),
		.enc_start(enc_start), .enc_sum(enc_sum), .enc_res1(enc_res1),
		.enc_v0(enc_v0), .enc_res2(enc_res2), .enc_v1(enc_v1),
		.dec_start(dec_start), .dec_res1(dec_res1), .dec_v1(dec_v1),
		.dec_res2(dec_res2), .dec_v0(dec_v0), .dec_sum(dec_sum),
		.v0_init(v0_init), .v1_init(v1_init),
		.k0(k0), .k1(k1), .k2(k2), .k3(k3),
		.v0(v0), .v1(v1)
	);

	result_display u_result_display (
		.clk(clk), .resetFlag(resetFlag), .abort(abort),
		.show_v0(show_v0), .show_v1(show_v1), .v0(v0), .v1(v1),
		.hex0(hex0), .hex1(hex1), .hex2(hex2),
		.hex3(hex3), .hex4(hex4), .hex5(hex5),
		.ledr(ledr)
	);

endmodule

// File: tb/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// active low segments in gfedcba order
localparam seg_t SEG_HEX [16] = '{
	7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
	7'h00, 7'h18, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
};

task automatic check_seg(input string name, input seg_t got, input seg_t exp);
	if (got !== exp)
		fail_run($sformatf("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp));
endtask

task automatic check_leds(input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp)
		fail_run($sformatf("Fail at %0d ns: ledr is %h, expected %h", $time, got, exp));
endtask

// plain TEA over 32 rounds
function automatic void tea_encrypt(inout word_t v0, inout word_t v1,
		input word_t k0, input word_t k1, input word_t k2, input word_t k3);
	word_t sum;
	sum = '0;
	for (int r = 0; r < TEA_ROUNDS; r++) begin
		sum = sum + TEA_DELTA;
		v0 = v0 + (((v1 << 4) + k0) ^ (v1 + sum) ^ ((v1 >> 5) + k1));
		v1 = v1 + (((v0 << 4) + k2) ^ (v0 + sum) ^ ((v0 >> 5) + k3));
	end
endfunction

// low half from lo and high half from hi
task automatic expect_display(input word_t lo, input word_t hi);
	word_t r;
	r = {hi[15:0], lo[15:0]};
	check_seg("hex0", hex0, SEG_HEX[r[3:0]]);
	check_seg("hex1", hex1, SEG_HEX[r[7:4]]);
	check_seg("hex2", hex2, SEG_HEX[r[11:8]]);
	check_seg("hex3", hex3, SEG_HEX[r[19:16]]);
	check_seg("hex4", hex4, SEG_HEX[r[23:20]]);
	check_seg("hex5", hex5, SEG_HEX[r[27:24]]);
	check_leds(ledr, {r[31:28], r[15:12]});
endtask

`endif

// File: tb/tb_tea_keypad.sv
`timescale 1ns/1ps

module tb_tea_keypad import tea_pkg::*; ();

	typedef enum logic [1:0] {CHK_NONE, CHK_ENC, CHK_DEC, CHK_ZERO} chk_t;
	typedef struct packed {
		scan_code_t code;
		chk_t chk;
	} step_t;

	localparam int N_STEPS = 56;
	localparam step_t STEPS [N_STEPS] = '{
		// 3 7 1 2 4 5, encrypt then decrypt
		'{SC_DIGIT[3], CHK_NONE}, '{SC_SPACE, CHK_NONE}, '{SC_DIGIT[7], CHK_NONE},
		'{SC_SPACE, CHK_NONE}, '{SC_DIGIT[1], CHK_NONE}, '{SC_SPACE, CHK_NONE},
		'{SC_DIGIT[2], CHK_NONE}, '{SC_SPACE, CHK_NONE}, '{SC_DIGIT[4], CHK_NONE},
		'{SC_SPACE, CHK_NONE}, '{SC_DIGIT[5], CHK_NONE}, '{SC_ENTER, CHK_NONE},
		'{SC_ENC, CHK_ENC}, '{SC_DEC, CHK_DEC},
		// releases and typematic spaces mixed in
		'{SC_DIGIT[9], CHK_NONE}, '{SC_BREAK, CHK_NONE}, '{SC_DIGIT[9], CHK_NONE},
		'{SC_SPACE, CHK_NONE}, '{SC_SPACE, CHK_NONE}, '{SC_BREAK, CHK_NONE},
		'{SC_SPACE, CHK_NONE}, '{SC_DIGIT[8], CHK_NONE}, '{SC_SPACE, CHK_NONE},
		'{SC_DIGIT[7], CHK_NONE}, '{SC_BREAK, CHK_NONE}, '{SC_DIGIT[7], CHK_NONE},
		'{SC_SPACE, CHK_NONE}, '{SC_SPACE, CHK_NONE}, '{SC_DIGIT[6], CHK_NONE},
		'{SC_SPACE, CHK_NONE}, '{SC_DIGIT[5], CHK_NONE}, '{SC_SPACE, CHK_NONE},
		'{SC_BREAK, CHK_NONE}, '{SC_SPACE, CHK_NONE}, '{SC_DIGIT[4], CHK_NONE},
		'{SC_ENTER, CHK_NONE}, '{SC_BREAK, CHK_NONE}, '{SC_ENTER, CHK_NONE},
		'{SC_ENC, CHK_ENC},
		// escape mid session, then a fresh run
		'{SC_ESC, CHK_ZERO}, '{SC_BREAK, CHK_NONE}, '{SC_ESC, CHK_NONE},
		'{SC_DIGIT[8], CHK_NONE}, '{SC_SPACE, CHK_NONE}, '{SC_DIGIT[0], CHK_NONE},
		'{SC_SPACE, CHK_NONE}, '{SC_DIGIT[6], CHK_NONE}, '{SC_SPACE, CHK_NONE},
		'{SC_DIGIT[9], CHK_NONE}, '{SC_SPACE, CHK_NONE}, '{SC_DIGIT[2], CHK_NONE},
		'{SC_SPACE, CHK_NONE}, '{SC_DIGIT[1], CHK_NONE}, '{SC_ENTER, CHK_NONE},
		'{SC_ENC, CHK_ENC}, '{SC_DEC, CHK_DEC}
	};

	logic clk;
	logic resetFlag;
	scan_code_t scan_code;
	logic scan_valid;
	seg_t hex0, hex1, hex2, hex3, hex4, hex5;
	logic [7:0] ledr;

	word_t ops [NUM_FIELDS]; // where each digit should land
	int field_ref;
	logic after_brk;
	logic space_held;
	logic loading;
	word_t plain0, plain1, ciph0, ciph1;

	tea_keypad_top u_tea_keypad_top (
		.clk(clk), .resetFlag(resetFlag),
		.scan_code(scan_code), .scan_valid(scan_valid),
		.hex0(hex0), .hex1(hex1), .hex2(hex2),
		.hex3(hex3), .hex4(hex4), .hex5(hex5),
		.ledr(ledr)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	`include "tb_checks.svh"

	function automatic int idle_cycles(input scan_code_t code);
		return (code == SC_ENC || code == SC_DEC) ? 200 : 4; // a full run fits in 170
	endfunction

	task automatic clear_entry();
		for (int i = 0; i < NUM_FIELDS; i++)
			ops[i] = '0;
		field_ref = 0;
		loading = 1'b1;
	endtask

	// keyboard entry rules, one code at a time
	task automatic track_entry(input scan_code_t code);
		logic is_make;
		is_make = code != SC_BREAK && !after_brk;
		for (int i = 0; i < 10; i++)
			if (loading && code == SC_DIGIT[i])
				ops[field_ref] = word_t'(i);
		if (loading && is_make && code == SC_SPACE && !space_held && field_ref < NUM_FIELDS - 1)
			field_ref++;
		if (is_make)
			space_held = code == SC_SPACE;
		after_brk = code == SC_BREAK;
		if (is_make && code == SC_ENTER)
			loading = 1'b0;
		if (is_make && code == SC_ENC) begin
			plain0 = ops[0];
			plain1 = ops[1];
			ciph0 = ops[0];
			ciph1 = ops[1];
			tea_encrypt(ciph0, ciph1, ops[2], ops[3], ops[4], ops[5]);
		end
		if (is_make && code == SC_DEC)
			clear_entry(); // operands wiped when the run ends
		if (is_make && code == SC_ESC) begin
			clear_entry();
			after_brk = 1'b0;
			space_held = 1'b0;
		end
	endtask

	task automatic apply_code(input scan_code_t code, input int idle);
		@(posedge clk);
		#1;
		scan_code = code;
		scan_valid = 1'b1;
		@(posedge clk);
		#1;
		scan_valid = 1'b0;
		repeat (idle) @(posedge clk);
		#1;
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin : watchdog
		int budget;
		budget = 20;
		for (int i = 0; i < N_STEPS; i++)
			budget = budget + 2 + idle_cycles(STEPS[i].code);
		#(budget * 8); // twice the expected span at 4 ns
		fail_run("watchdog expired before all checks were done");
	end

	initial begin
		resetFlag = 1'b1;
		scan_code = '0;
		scan_valid = 1'b0;
		after_brk = 1'b0;
		space_held = 1'b0;
		clear_entry();
		repeat (10) @(posedge clk);
		#1;
		resetFlag = 1'b0;
		@(posedge clk);
		#1;
		expect_display('0, '0);
		for (int i = 0; i < N_STEPS; i++) begin
			track_entry(STEPS[i].code);
			apply_code(STEPS[i].code, idle_cycles(STEPS[i].code));
			case (STEPS[i].chk)
				CHK_ENC: expect_display(ciph0, ciph1);
				CHK_DEC: expect_display(plain0, plain1);
				CHK_ZERO: expect_display('0, '0);
				default: ;
			endcase
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

// File: compile.f
+incdir+tb
logic/tea_pkg.sv
logic/scan_entry.sv
logic/operand_regs.sv
logic/tea_round_unit.sv
logic/tea_sequencer.sv
logic/result_display.sv
logic/tea_keypad_top.sv
tb/tb_tea_keypad.sv
